//--- include/bypassCore_settings.svh
`ifndef BYPASSCORE_SETTINGS_SVH
`define BYPASSCORE_SETTINGS_SVH

// Data word width.
`define DATA_W 32

// Register address width for 32 architectural registers.
`define REG_AW 5

// JAL writes the link register with PC plus the link offset.
`define LINK_REG 31
`define LINK_OFS 8

`endif

//--- design/pipePkg.sv
package pipePkg;

	// Instruction kinds seen by the execute stage.
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SLT  = 4'd6,
		OP_ADDI = 4'd7,
		OP_ORI  = 4'd8,
		OP_SLTI = 4'd9,
		OP_LUI  = 4'd10,
		OP_JAL  = 4'd11
	} opcode_e;

	// ALU function decoded from the opcode.
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} aluOp_e;

	typedef enum logic [1:0] {
		RES_ALU   = 2'd0,
		RES_IMMHI = 2'd1,
		RES_LINK  = 2'd2
	} resultSel_e;

	// Operand source. Pipeline stages are listed youngest first.
	typedef enum logic [1:0] {
		FWD_REGFILE = 2'd0,
		FWD_MEM1    = 2'd1,
		FWD_MEM2    = 2'd2,
		FWD_WB      = 2'd3
	} fwdSel_e;

endpackage

//--- design/regFile.sv
`include "bypassCore_settings.svh"

module regFile (
	input  logic               clk,
	input  logic               rst,
	input  logic [`REG_AW-1:0] rdAddrA,
	input  logic [`REG_AW-1:0] rdAddrB,
	input  logic               wrEn,
	input  logic [`REG_AW-1:0] wrAddr,
	input  logic [`DATA_W-1:0] wrData,
	output logic [`DATA_W-1:0] rdDataA,
	output logic [`DATA_W-1:0] rdDataB
);

	localparam int NumRegs = 1 << `REG_AW;

	logic [`DATA_W-1:0] regs [NumRegs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle write is not visible here.
	// The WB forward path supplies it instead.
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- design/bypassMux.sv
`include "bypassCore_settings.svh"

module bypassMux import pipePkg::*; (
	input  fwdSel_e            fwdSel,
	input  logic [`DATA_W-1:0] regVal,
	input  logic [`DATA_W-1:0] mem1Val,
	input  logic [`DATA_W-1:0] mem2Val,
	input  logic [`DATA_W-1:0] wbVal,
	output logic [`DATA_W-1:0] operand
);

	always_comb begin
		case (fwdSel)
			FWD_MEM1: operand = mem1Val;
			FWD_MEM2: operand = mem2Val;
			FWD_WB:   operand = wbVal;
			default:  operand = regVal;
		endcase
	end

endmodule

//--- design/execUnit.sv
`include "bypassCore_settings.svh"

module execUnit import pipePkg::*; (
	input  aluOp_e             aluOp,
	input  logic [`DATA_W-1:0] operandA,
	input  logic [`DATA_W-1:0] operandB,
	input  logic               useImm,
	input  logic [`DATA_W-1:0] immValue,
	input  resultSel_e         resultSel,
	input  logic [`DATA_W-1:0] linkValue,
	output logic [`DATA_W-1:0] exResult
);

	logic [`DATA_W-1:0] aluB;
	logic [`DATA_W-1:0] aluOut;
	logic [`DATA_W-1:0] immHi;

	assign aluB  = useImm ? immValue : operandB;
	assign immHi = {immValue[15:0], 16'b0};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (aluOp)
			ALU_SUB: aluOut = operandA - aluB;
			ALU_AND: aluOut = operandA & aluB;
			ALU_OR:  aluOut = operandA | aluB;
			ALU_XOR: aluOut = operandA ^ aluB;
			ALU_SLT: begin
				aluOut = {{(`DATA_W-1){1'b0}}, $signed(operandA) < $signed(aluB)};
			end
			default: aluOut = operandA + aluB;
		endcase
	end

	// Result select.
	always_comb begin
		case (resultSel)
			RES_IMMHI: exResult = immHi;
			RES_LINK:  exResult = linkValue;
			default:   exResult = aluOut;
		endcase
	end

endmodule

//--- design/resultPipe.sv
`include "bypassCore_settings.svh"

module resultPipe (
	input  logic               clk,
	input  logic               rst,
	input  logic               exValid,
	input  logic [`REG_AW-1:0] exDest,
	input  logic [`DATA_W-1:0] exResult,
	output logic               mem1Valid,
	output logic [`REG_AW-1:0] mem1Dest,
	output logic [`DATA_W-1:0] mem1Data,
	output logic               mem2Valid,
	output logic [`REG_AW-1:0] mem2Dest,
	output logic [`DATA_W-1:0] mem2Data,
	output logic               wbValid,
	output logic [`REG_AW-1:0] wbDest,
	output logic [`DATA_W-1:0] wbData
);

	// Valid bits.
	always_ff @(posedge clk) begin
		if (rst) begin
			mem1Valid <= 1'b0;
			mem2Valid <= 1'b0;
			wbValid   <= 1'b0;
		end else begin
			mem1Valid <= exValid;
			mem2Valid <= mem1Valid;
			wbValid   <= mem2Valid;
		end
	end

	// Destination and data shift along with valid.
	always_ff @(posedge clk) begin
		mem1Dest <= exDest;
		mem1Data <= exResult;
		mem2Dest <= mem1Dest;
		mem2Data <= mem1Data;
		wbDest   <= mem2Dest;
		wbData   <= mem2Data;
	end

endmodule

//--- design/issueCtrl.sv
`include "bypassCore_settings.svh"

module issueCtrl import pipePkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               instrValid,
	input  opcode_e            op,
	input  logic [`REG_AW-1:0] rs,
	input  logic [`REG_AW-1:0] rt,
	input  logic [`REG_AW-1:0] rd,
	input  logic [15:0]        imm,
	input  logic [`DATA_W-1:0] pc,
	input  logic               mem1Valid,
	input  logic [`REG_AW-1:0] mem1Dest,
	input  logic               mem2Valid,
	input  logic [`REG_AW-1:0] mem2Dest,
	input  logic               wbValid,
	input  logic [`REG_AW-1:0] wbDest,
	output logic [`REG_AW-1:0] rdAddrA,
	output logic [`REG_AW-1:0] rdAddrB,
	output fwdSel_e            fwdSelA,
	output fwdSel_e            fwdSelB,
	output aluOp_e             aluOp,
	output logic               useImm,
	output logic [`DATA_W-1:0] immValue,
	output resultSel_e         resultSel,
	output logic [`DATA_W-1:0] linkValue,
	output logic               exValid,
	output logic [`REG_AW-1:0] exDest
);

	opcode_e            exOp;
	logic [`REG_AW-1:0] exRs;
	logic [`REG_AW-1:0] exRt;
	logic [`REG_AW-1:0] exRd;
	logic [15:0]        exImm;
	logic [`DATA_W-1:0] exPc;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// EX stage register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			exValid <= 1'b0;
		end else begin
			exValid <= instrValid && (op != OP_NOP);
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			exOp  <= op;
			exRs  <= rs;
			exRt  <= rt;
			exRd  <= rd;
			exImm <= imm;
			exPc  <= pc;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		aluOp     = ALU_ADD;
		useImm    = 1'b0;
		immValue  = {{16{exImm[15]}}, exImm};
		resultSel = RES_ALU;
		exDest    = exRd;
		case (exOp)
			OP_SUB: aluOp = ALU_SUB;
			OP_AND: aluOp = ALU_AND;
			OP_OR:  aluOp = ALU_OR;
			OP_XOR: aluOp = ALU_XOR;
			OP_SLT: aluOp = ALU_SLT;
			OP_ADDI: begin
				useImm = 1'b1;
				exDest = exRt;
			end
			OP_ORI: begin
				aluOp    = ALU_OR;
				useImm   = 1'b1;
				immValue = {16'b0, exImm};	// zero-extended
				exDest   = exRt;
			end
			OP_SLTI: begin
				aluOp  = ALU_SLT;
				useImm = 1'b1;
				exDest = exRt;
			end
			OP_LUI: begin
				resultSel = RES_IMMHI;
				exDest    = exRt;
			end
			OP_JAL: begin
				resultSel = RES_LINK;
				exDest    = `REG_AW'(`LINK_REG);
			end
			default: ;
		endcase
	end

	assign linkValue = exPc + `DATA_W'(`LINK_OFS);
	assign rdAddrA   = exRs;
	assign rdAddrB   = exRt;

	// Youngest matching stage wins. r0 is never forwarded.
	function automatic fwdSel_e pickSource(input logic [`REG_AW-1:0] src);
		fwdSel_e sel;
		sel = FWD_REGFILE;
		if (src != '0) begin
			if (mem1Valid && (mem1Dest == src)) begin
				sel = FWD_MEM1;
			end else if (mem2Valid && (mem2Dest == src)) begin
				sel = FWD_MEM2;
			end else if (wbValid && (wbDest == src)) begin
				sel = FWD_WB;
			end
		end
		return sel;
	endfunction

	always_comb begin
		fwdSelA = pickSource(exRs);
		fwdSelB = pickSource(exRt);
	end

endmodule

//--- design/bypassCore.sv
`include "bypassCore_settings.svh"

module bypassCore import pipePkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               instrValid,
	input  opcode_e            op,
	input  logic [`REG_AW-1:0] rs,
	input  logic [`REG_AW-1:0] rt,
	input  logic [`REG_AW-1:0] rd,
	input  logic [15:0]        imm,
	input  logic [`DATA_W-1:0] pc,
	output logic               wbValid,
	output logic [`REG_AW-1:0] wbAddr,
	output logic [`DATA_W-1:0] wbData
);

	logic [`REG_AW-1:0] rdAddrA;
	logic [`REG_AW-1:0] rdAddrB;
	fwdSel_e            fwdSelA;
	fwdSel_e            fwdSelB;
	aluOp_e             aluOp;
	logic               useImm;
	logic [`DATA_W-1:0] immValue;
	resultSel_e         resultSel;
	logic [`DATA_W-1:0] linkValue;
	logic               exValid;
	logic [`REG_AW-1:0] exDest;
	logic [`DATA_W-1:0] exResult;
	logic [`DATA_W-1:0] rdDataA;
	logic [`DATA_W-1:0] rdDataB;
	logic [`DATA_W-1:0] operandA;
	logic [`DATA_W-1:0] operandB;
	logic               mem1Valid;
	logic [`REG_AW-1:0] mem1Dest;
	logic [`DATA_W-1:0] mem1Data;
	logic               mem2Valid;
	logic [`REG_AW-1:0] mem2Dest;
	logic [`DATA_W-1:0] mem2Data;

	issueCtrl ctrl (
		.clk(clk), .rst(rst), .instrValid(instrValid), .op(op),
		.rs(rs), .rt(rt), .rd(rd), .imm(imm), .pc(pc),
		.mem1Valid(mem1Valid), .mem1Dest(mem1Dest),
		.mem2Valid(mem2Valid), .mem2Dest(mem2Dest),
		.wbValid(wbValid), .wbDest(wbAddr),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
		.aluOp(aluOp), .useImm(useImm), .immValue(immValue),
		.resultSel(resultSel), .linkValue(linkValue),
		.exValid(exValid), .exDest(exDest)
	);

	// Write port is fed straight from the WB stage.
	regFile regs (
		.clk(clk), .rst(rst),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.wrEn(wbValid), .wrAddr(wbAddr), .wrData(wbData),
		.rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	bypassMux bypassA (
		.fwdSel(fwdSelA), .regVal(rdDataA),
		.mem1Val(mem1Data), .mem2Val(mem2Data), .wbVal(wbData),
		.operand(operandA)
	);

	bypassMux bypassB (
		.fwdSel(fwdSelB), .regVal(rdDataB),
		.mem1Val(mem1Data), .mem2Val(mem2Data), .wbVal(wbData),
		.operand(operandB)
	);

	execUnit exec (
		.aluOp(aluOp), .operandA(operandA), .operandB(operandB),
		.useImm(useImm), .immValue(immValue),
		.resultSel(resultSel), .linkValue(linkValue),
		.exResult(exResult)
	);

	resultPipe pipe (
		.clk(clk), .rst(rst),
		.exValid(exValid), .exDest(exDest), .exResult(exResult),
		.mem1Valid(mem1Valid), .mem1Dest(mem1Dest), .mem1Data(mem1Data),
		.mem2Valid(mem2Valid), .mem2Dest(mem2Dest), .mem2Data(mem2Data),
		.wbValid(wbValid), .wbDest(wbAddr), .wbData(wbData)
	);

endmodule

//--- test/bypassCore_props.sv
`include "bypassCore_settings.svh"

module bypassCore_props import pipePkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               instrValid,
	input  opcode_e            op,
	input  logic               wbValid,
	input  logic [`DATA_W-1:0] wbData
);

	timeunit 1ns;
	timeprecision 100ps;

	int issueCount = 0;
	int wbCount = 0;
	int failCount = 0;

	// Accepted non-NOP instructions against writeback pulses.
	always @(posedge clk) begin
		if (rst) begin
			issueCount <= 0;
			wbCount <= 0;
		end else begin
			if (instrValid && (op != OP_NOP)) begin
				issueCount <= issueCount + 1;
			end
			if (wbValid) begin
				wbCount <= wbCount + 1;
			end
		end
	end

	wbQuietInReset: assert property (@(posedge clk) (rst || $fell(rst)) |=> !wbValid)
		else begin
			failCount++;
			$error("wbValid high during reset or the cycle after");
		end

	wbDataKnown: assert property (@(posedge clk) disable iff (rst)
		wbValid |-> !$isunknown(wbData))
		else begin
			failCount++;
			$error("wbData unknown while wbValid is high");
		end

	wbNotAheadOfIssue: assert property (@(posedge clk) disable iff (rst)
		(wbCount + (wbValid ? 1 : 0)) <= issueCount)
		else begin
			failCount++;
			$error("More writebacks than accepted instructions");
		end

endmodule

bind bypassCore bypassCore_props props (
	.clk(clk), .rst(rst), .instrValid(instrValid), .op(op),
	.wbValid(wbValid), .wbData(wbData)
);

//--- test/bypassCore_tb.sv
`include "bypassCore_settings.svh"

module bypassCore_tb import pipePkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ClkPeriod   = 4;
	localparam int ResetCycles = 10;
	localparam int NumInstr    = 2000;
	localparam int Seed        = 91516;

	logic               clk;
	logic               rst;
	logic               instrValid;
	opcode_e            op;
	logic [`REG_AW-1:0] rs;
	logic [`REG_AW-1:0] rt;
	logic [`REG_AW-1:0] rd;
	logic [15:0]        imm;
	logic [`DATA_W-1:0] pc;
	logic               wbValid;
	logic [`REG_AW-1:0] wbAddr;
	logic [`DATA_W-1:0] wbData;

	// Architectural state and the writebacks still owed by the DUT.
	logic [`DATA_W-1:0] archRegs [32];
	logic [`REG_AW-1:0] expAddrQ [$];
	logic [`DATA_W-1:0] expDataQ [$];
	int                 errorCount;
	int                 wbCount;

	bypassCore dut (
		.clk(clk), .rst(rst), .instrValid(instrValid), .op(op),
		.rs(rs), .rt(rt), .rd(rd), .imm(imm), .pc(pc),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

	initial clk = 1'b0;
	always #(ClkPeriod / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [`DATA_W-1:0] modelResult(input opcode_e kind,
			input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
			input logic [15:0] k, input logic [`DATA_W-1:0] addr);
		logic [`DATA_W-1:0] sext;
		logic [`DATA_W-1:0] zext;
		logic [`DATA_W-1:0] res;
		sext = {{16{k[15]}}, k};
		zext = {16'h0000, k};
		case (kind)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_SLT:  res = ($signed(a) < $signed(b)) ? `DATA_W'(1) : '0;
			OP_ADDI: res = a + sext;
			OP_ORI:  res = a | zext;
			OP_SLTI: res = ($signed(a) < $signed(sext)) ? `DATA_W'(1) : '0;
			OP_LUI:  res = {k, 16'h0000};
			OP_JAL:  res = addr + `DATA_W'(`LINK_OFS);
			default: res = '0;
		endcase
		return res;
	endfunction

	// Immediate forms target rt, JAL the link register, the rest rd.
	function automatic logic [`REG_AW-1:0] modelDest(input opcode_e kind,
			input logic [`REG_AW-1:0] t, input logic [`REG_AW-1:0] d);
		logic [`REG_AW-1:0] dest;
		case (kind)
			OP_ADDI, OP_ORI, OP_SLTI, OP_LUI: dest = t;
			OP_JAL:  dest = `REG_AW'(`LINK_REG);
			default: dest = d;
		endcase
		return dest;
	endfunction

	// Mostly r0..r3 so that back-to-back dependencies are common.
	function automatic logic [`REG_AW-1:0] randReg();
		logic [`REG_AW-1:0] r;
		if ($urandom_range(9, 0) < 8) begin
			r = `REG_AW'($urandom_range(3, 0));
		end else begin
			r = `REG_AW'($urandom_range(31, 0));
		end
		return r;
	endfunction

	task automatic checkValue(input logic [`DATA_W-1:0] actual,
			input logic [`DATA_W-1:0] expected, input string what);
		if (actual !== expected) begin
			errorCount++;
			$display("ERR @%0d ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic checkWriteback();
		logic [`REG_AW-1:0] expAddr;
		logic [`DATA_W-1:0] expData;
		if (wbValid === 1'b1) begin
			wbCount++;
			if (expAddrQ.size() == 0) begin
				errorCount++;
				$display("Writeback at %0d ns with no instruction pending", $time);
			end else begin
				expAddr = expAddrQ.pop_front();
				expData = expDataQ.pop_front();
				checkValue(`DATA_W'(wbAddr), `DATA_W'(expAddr), "wbAddr");
				checkValue(wbData, expData, "wbData");
			end
		end else if (wbValid !== 1'b0) begin
			errorCount++;
			$display("wbValid is unknown at %0d ns", $time);
		end
	endtask

	// One issue slot. The model runs at acceptance, in program order.
	task automatic driveSlot();
		int                 pick;
		opcode_e            kind;
		logic [`DATA_W-1:0] res;
		logic [`REG_AW-1:0] dest;
		pick = $urandom_range(99, 0);
		kind = opcode_e'(4'($urandom_range(11, 0)));
		instrValid = (pick >= 10);
		op = kind;
		rs = randReg();
		rt = randReg();
		rd = randReg();
		imm = 16'($urandom());
		pc = $urandom() & 32'hFFFF_FFFC;
		if (instrValid && (kind != OP_NOP)) begin
			res = modelResult(kind, archRegs[rs], archRegs[rt], imm, pc);
			dest = modelDest(kind, rt, rd);
			expAddrQ.push_back(dest);
			expDataQ.push_back(res);
			if (dest != '0) begin
				archRegs[dest] = res;
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		void'($urandom(Seed));
		errorCount = 0;
		wbCount = 0;
		rst = 1'b1;
		instrValid = 1'b0;
		op = OP_NOP;
		rs = '0;
		rt = '0;
		rd = '0;
		imm = '0;
		pc = '0;
		for (int i = 0; i < 32; i++) begin
			archRegs[i] = '0;
		end

		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checkWriteback();

		for (int n = 0; n < NumInstr; n++) begin
			@(negedge clk);
			checkWriteback();
			driveSlot();
		end

		@(negedge clk);
		checkWriteback();
		instrValid = 1'b0;
		op = OP_NOP;

		// Drain, then make sure nothing extra comes out.
		while (expAddrQ.size() != 0) begin
			@(negedge clk);
			checkWriteback();
		end
		repeat (4) begin
			@(negedge clk);
			checkWriteback();
		end

		$display("Writebacks: %0d, errors: %0d, assertion failures: %0d",
			wbCount, errorCount, dut.props.failCount);
		if ((errorCount == 0) && (dut.props.failCount == 0)) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#((ResetCycles + NumInstr + 20) * ClkPeriod);
		$display("Run timed out before all writebacks were seen");
		$display("Checks failed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
design/pipePkg.sv
design/regFile.sv
design/bypassMux.sv
design/execUnit.sv
design/resultPipe.sv
design/issueCtrl.sv
design/bypassCore.sv
test/bypassCore_props.sv
test/bypassCore_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module bypassCore_tb -f flist.f -o simv

output=$(./obj_dir/simv +verilator+error+limit+1000 || true)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
	exit 0
fi
exit 1
